//--- rtl/rx_link_pkg.sv
`default_nettype none

package rx_link_pkg;

  // one received data byte
  typedef logic [7:0] byte_t;

  // crc register value
  typedef logic [7:0] crc_t;

  // x^8 + x^2 + x + 1, msb first, init zero
  localparam crc_t CRC_POLY = 8'h07;

  typedef enum logic [1:0]
  {
    LINK_IDLE  = 2'd0, // waiting for a locked frame start
    LINK_RECV  = 2'd1, // bytes going into buffer and crc
    LINK_CLOSE = 2'd2  // one cycle for the last crc update
  } link_state_t;

  typedef enum logic [1:0]
  {
    STAT_OK       = 2'd0,
    STAT_CRC_ERR  = 2'd1, // residue not zero
    STAT_RUNT     = 2'd2, // fewer than two bytes
    STAT_OVERFLOW = 2'd3  // more bytes than the buffer holds
  } frame_status_t;

endpackage

`default_nettype wire

//--- rtl/rx_bit_framer.sv
`timescale 1ns/100ps
`default_nettype none

module rx_bit_framer
(
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  fram,
  input  wire                  bit_in,
  input  wire                  bit_strobe,
  output logic                 frame_start,
  output logic                 frame_end,
  output logic                 byte_valid,
  output rx_link_pkg::byte_t   rx_byte
);

  import rx_link_pkg::*;

  logic [1:0] fram_sync;
  logic [1:0] bit_sync;
  logic [1:0] strobe_sync;
  logic [1:0] fram_hist;   // delayed copies of synced gate
  logic [2:0] bit_cnt;
  byte_t      shift_reg;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fram_sync   <= 2'b00;
      bit_sync    <= 2'b00;
      strobe_sync <= 2'b00;
      fram_hist   <= 2'b00;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      byte_valid  <= 1'b0;
      bit_cnt     <= 3'd0;
    end
    else
    begin
      fram_sync   <= {fram_sync[0], fram};
      bit_sync    <= {bit_sync[0], bit_in};
      strobe_sync <= {strobe_sync[0], bit_strobe};
      fram_hist   <= {fram_hist[0], fram_sync[1]};
      frame_start <= (fram_hist == 2'b01);
      frame_end   <= (fram_hist == 2'b10);
      byte_valid  <= 1'b0;
      if (fram_sync[1] && !fram_hist[0])
        bit_cnt <= 3'd0; // new frame, drop any stale partial byte
      else if (fram_sync[1] && strobe_sync[1])
      begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          byte_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fram_sync[1] && strobe_sync[1])
      shift_reg <= {shift_reg[6:0], bit_sync[1]}; // msb first
  end

  assign rx_byte = shift_reg;

  a_edges_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(frame_start && frame_end));

endmodule

`default_nettype wire

//--- rtl/rx_link_control.sv
`timescale 1ns/100ps
`default_nettype none

module rx_link_control
#(
  parameter int ADDR_W = 11
)
(
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  phaselock,
  input  wire                  frame_start,
  input  wire                  frame_end,
  input  wire                  byte_valid,
  input  rx_link_pkg::byte_t   rx_byte,
  output logic                 rx_start,
  output logic                 rx_busy,
  output logic                 wen,
  output logic [ADDR_W-1:0]    waddr,
  output rx_link_pkg::byte_t   wdata,
  output logic                 crc_init,
  output logic                 crc_en,
  output rx_link_pkg::byte_t   crc_byte,
  output logic                 crc_end,
  output logic [ADDR_W:0]      byte_count,
  output logic                 overflow
);

  import rx_link_pkg::*;

  localparam logic [ADDR_W:0] DEPTH = 1 << ADDR_W;

  link_state_t state;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= LINK_IDLE;
      rx_start   <= 1'b0;
      wen        <= 1'b0;
      crc_init   <= 1'b0;
      crc_en     <= 1'b0;
      crc_end    <= 1'b0;
      byte_count <= '0;
      overflow   <= 1'b0;
    end
    else
    begin
      rx_start <= 1'b0;
      wen      <= 1'b0;
      crc_init <= 1'b0;
      crc_en   <= 1'b0;
      crc_end  <= 1'b0;
      case (state)
        LINK_IDLE:
        begin
          if (frame_start && phaselock)
          begin
            state      <= LINK_RECV;
            rx_start   <= 1'b1;
            crc_init   <= 1'b1;
            byte_count <= '0;
            overflow   <= 1'b0;
          end
        end
        LINK_RECV:
        begin
          if (byte_valid)
          begin
            if (byte_count < DEPTH)
            begin
              wen        <= 1'b1;
              crc_en     <= 1'b1;
              byte_count <= byte_count + 1'b1;
            end
            else
              overflow <= 1'b1; // buffer full so the byte is dropped
          end
          if (frame_end)
          begin
            state   <= LINK_CLOSE;
            crc_end <= 1'b1; // high while in LINK_CLOSE
          end
        end
        LINK_CLOSE:
          state <= LINK_IDLE;
        default:
          state <= LINK_IDLE;
      endcase
    end
  end

  // payload held for the buffer write and the crc update
  always_ff @(posedge clk)
  begin
    if (state == LINK_RECV && byte_valid)
    begin
      waddr    <= byte_count[ADDR_W-1:0];
      wdata    <= rx_byte;
      crc_byte <= rx_byte;
    end
  end

  assign rx_busy = (state != LINK_IDLE);

  a_wen_in_recv: assert property (@(posedge clk) disable iff (reset)
    wen |-> state == LINK_RECV);

  a_crc_end_single: assert property (@(posedge clk) disable iff (reset)
    crc_end |=> !crc_end);

endmodule

`default_nettype wire

//--- rtl/crc8_engine.sv
`timescale 1ns/100ps
`default_nettype none

module crc8_engine
(
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  crc_init,
  input  wire                  crc_en,
  input  rx_link_pkg::byte_t   crc_byte,
  output rx_link_pkg::crc_t    crc
);

  import rx_link_pkg::*;

  crc_t crc_next;

  // eight shift steps of the serial divider, unrolled
  always_comb
  begin
    crc_next = crc ^ crc_byte;
    for (int i = 0; i < 8; i++)
    begin
      if (crc_next[7])
        crc_next = {crc_next[6:0], 1'b0} ^ CRC_POLY;
      else
        crc_next = {crc_next[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      crc <= '0;
    else if (crc_init)
      crc <= '0; // init wins over update
    else if (crc_en)
      crc <= crc_next;
  end

endmodule

`default_nettype wire

//--- rtl/frame_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_buffer
#(
  parameter int ADDR_W = 11
)
(
  input  wire                  clk,
  input  wire                  wen,
  input  wire [ADDR_W-1:0]     waddr,
  input  rx_link_pkg::byte_t   wdata,
  input  wire [ADDR_W-1:0]     rd_addr,
  output rx_link_pkg::byte_t   rd_data
);

  import rx_link_pkg::*;

  byte_t mem [2**ADDR_W];

  always_ff @(posedge clk)
  begin
    if (wen)
      mem[waddr] <= wdata;
  end

  // registered read, data one cycle after address
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- rtl/frame_status.sv
`timescale 1ns/100ps
`default_nettype none

module frame_status
#(
  parameter int ADDR_W = 11
)
(
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          crc_end,
  input  rx_link_pkg::crc_t            crc,
  input  wire [ADDR_W:0]               byte_count,
  input  wire                          overflow,
  output logic                         frame_done,
  output rx_link_pkg::frame_status_t   frame_status,
  output logic [ADDR_W:0]              frame_len
);

  import rx_link_pkg::*;

  frame_status_t status_next;

  always_comb
  begin
    if (overflow)
      status_next = STAT_OVERFLOW;
    else if (byte_count < 2)
      status_next = STAT_RUNT; // no room for data plus crc
    else if (crc != '0)
      status_next = STAT_CRC_ERR;
    else
      status_next = STAT_OK;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      frame_done   <= 1'b0;
      frame_status <= STAT_OK;
      frame_len    <= '0;
    end
    else
    begin
      frame_done <= crc_end;
      if (crc_end)
      begin
        frame_status <= status_next;
        frame_len    <= byte_count; // held until next frame
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rx_link_top.sv
`timescale 1ns/100ps
`default_nettype none

module rx_link_top
#(
  parameter int ADDR_W = 11
)
(
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          phaselock,
  input  wire                          fram,
  input  wire                          bit_in,
  input  wire                          bit_strobe,
  input  wire [ADDR_W-1:0]             rd_addr,
  output logic                         rx_start,
  output logic                         rx_busy,
  output logic                         frame_done,
  output rx_link_pkg::frame_status_t   frame_status,
  output logic [ADDR_W:0]              frame_len,
  output rx_link_pkg::byte_t           rd_data
);

  import rx_link_pkg::*;

  logic              frame_start;
  logic              frame_end;
  logic              byte_valid;
  byte_t             rx_byte;
  logic              wen;
  logic [ADDR_W-1:0] waddr;
  byte_t             wdata;
  logic              crc_init;
  logic              crc_en;
  byte_t             crc_byte;
  logic              crc_end;
  crc_t              crc;
  logic [ADDR_W:0]   byte_count;
  logic              overflow;

  rx_bit_framer u_framer
  (
    .clk         (clk),
    .reset       (reset),
    .fram        (fram),
    .bit_in      (bit_in),
    .bit_strobe  (bit_strobe),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte)
  );

  rx_link_control #(.ADDR_W(ADDR_W)) u_control
  (
    .clk         (clk),
    .reset       (reset),
    .phaselock   (phaselock),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte),
    .rx_start    (rx_start),
    .rx_busy     (rx_busy),
    .wen         (wen),
    .waddr       (waddr),
    .wdata       (wdata),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_byte    (crc_byte),
    .crc_end     (crc_end),
    .byte_count  (byte_count),
    .overflow    (overflow)
  );

  crc8_engine u_crc
  (
    .clk      (clk),
    .reset    (reset),
    .crc_init (crc_init),
    .crc_en   (crc_en),
    .crc_byte (crc_byte),
    .crc      (crc)
  );

  frame_buffer #(.ADDR_W(ADDR_W)) u_buffer
  (
    .clk     (clk),
    .wen     (wen),
    .waddr   (waddr),
    .wdata   (wdata),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  frame_status #(.ADDR_W(ADDR_W)) u_status
  (
    .clk          (clk),
    .reset        (reset),
    .crc_end      (crc_end),
    .crc          (crc),
    .byte_count   (byte_count),
    .overflow     (overflow),
    .frame_done   (frame_done),
    .frame_status (frame_status),
    .frame_len    (frame_len)
  );

endmodule

`default_nettype wire

//--- bench/tb_rx_link.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rx_link;

  import rx_link_pkg::*;

  localparam int ADDR_W       = 4;
  localparam int DEPTH        = 1 << ADDR_W;
  localparam int N_TESTS      = 6;
  localparam int DONE_TIMEOUT = 40;
  localparam logic [7:0] POLY = 8'h07;

  // one column per array: name, phaselock, payload bytes, corrupt crc, trailing bits
  string test_name   [N_TESTS] = '{"good_6", "crc_err", "runt_1", "overflow_20",
                                   "no_lock", "extra_bits"};
  bit    row_lock    [N_TESTS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
  int    row_payload [N_TESTS] = '{6, 6, 0, 19, 6, 4};
  bit    row_corrupt [N_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
  int    row_extra   [N_TESTS] = '{0, 0, 0, 0, 5, 3};

  logic              clk;
  logic              reset;
  logic              phaselock;
  logic              fram;
  logic              bit_in;
  logic              bit_strobe;
  logic [ADDR_W-1:0] rd_addr;
  logic              rx_start;
  logic              rx_busy;
  logic              frame_done;
  frame_status_t     frame_status;
  logic [ADDR_W:0]   frame_len;
  byte_t             rd_data;

  byte_t frame_bytes [$];
  string cur_test;
  int    errors;
  int    checks;
  int    test_errors;
  int    start_count;
  bit    in_frame;

  rx_link_top #(.ADDR_W(ADDR_W)) UUT
  (
    .clk          (clk),
    .reset        (reset),
    .phaselock    (phaselock),
    .fram         (fram),
    .bit_in       (bit_in),
    .bit_strobe   (bit_strobe),
    .rd_addr      (rd_addr),
    .rx_start     (rx_start),
    .rx_busy      (rx_busy),
    .frame_done   (frame_done),
    .frame_status (frame_status),
    .frame_len    (frame_len),
    .rd_data      (rd_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // bitwise serial divider, msb first
  function automatic logic [7:0] crc8_model(input logic [7:0] c, input logic [7:0] b);
    logic fb;
    for (int i = 7; i >= 0; i--)
    begin
      fb = c[7] ^ b[i];
      c  = {c[6:0], 1'b0};
      if (fb)
        c = c ^ POLY;
    end
    return c;
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_status(input frame_status_t exp, input frame_status_t act);
    checks++;
    if (exp !== act)
    begin
      note_error();
      $display("FAIL %s status: expected %s actual %s", cur_test, exp.name(), act.name());
    end
  endtask

  task automatic check_len(input logic [ADDR_W:0] exp, input logic [ADDR_W:0] act);
    checks++;
    if (exp !== act)
    begin
      note_error();
      $display("FAIL %s frame_len: expected %0d actual %0d", cur_test, exp, act);
    end
  endtask

  task automatic check_byte(input int addr, input byte_t exp, input byte_t act);
    checks++;
    if (exp !== act)
    begin
      note_error();
      $display("FAIL %s byte %0d: expected %h actual %h", cur_test, addr, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      note_error();
      $display("FAIL %s %s: expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  // rx_busy must cover rx_start up to frame_done
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (rx_start)
      begin
        start_count++;
        in_frame = 1'b1;
      end
      if (frame_done)
        in_frame = 1'b0;
      if (in_frame)
        check_flag("rx_busy", 1'b1, rx_busy);
    end
  end

  task automatic send_bit(input logic b);
    bit_in     = b;
    bit_strobe = 1'b1;
    @(negedge clk);
    bit_strobe = 1'b0;
    @(negedge clk);
  endtask

  task automatic send_frame(input int extra);
    fram = 1'b1;
    repeat (4) @(negedge clk); // let the gate edge pass the synchronizer
    foreach (frame_bytes[i])
      for (int b = 7; b >= 0; b--)
        send_bit(frame_bytes[i][b]);
    for (int i = 0; i < extra; i++)
      send_bit(1'($urandom_range(0, 1))); // partial byte
    repeat (2) @(negedge clk);
    fram = 1'b0;
  endtask

  task automatic wait_done(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < DONE_TIMEOUT && !seen; n++)
    begin
      @(negedge clk);
      if (frame_done)
        seen = 1'b1;
    end
  endtask

  task automatic read_buffer(input int count);
    for (int i = 0; i < count; i++)
    begin
      rd_addr = ADDR_W'(i);
      @(negedge clk);
      check_byte(i, frame_bytes[i], rd_data);
    end
  endtask

  initial
  begin
    int            n_total;
    int            exp_len;
    logic [7:0]    crc_run;
    logic [7:0]    residue;
    frame_status_t exp_status;
    bit            got_done;
    void'($urandom(32'hfddd));
    reset       = 1'b1;
    phaselock   = 1'b0;
    fram        = 1'b0;
    bit_in      = 1'b0;
    bit_strobe  = 1'b0;
    rd_addr     = '0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    start_count = 0;
    in_frame    = 1'b0;
    cur_test    = "reset";
    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_flag("rx_busy after reset", 1'b0, rx_busy);
    check_flag("frame_done after reset", 1'b0, frame_done);
    for (int t = 0; t < N_TESTS; t++)
    begin
      cur_test    = test_name[t];
      test_errors = 0;
      start_count = 0;
      phaselock   = row_lock[t];
      frame_bytes.delete();
      crc_run = 8'h00;
      for (int i = 0; i < row_payload[t]; i++)
      begin
        frame_bytes.push_back(byte_t'($urandom));
        crc_run = crc8_model(crc_run, frame_bytes[i]);
      end
      frame_bytes.push_back(row_corrupt[t] ? (crc_run ^ 8'h01) : crc_run);
      n_total = frame_bytes.size();
      residue = crc8_model(crc_run, frame_bytes[n_total-1]);
      if (n_total > DEPTH)
        exp_status = STAT_OVERFLOW;
      else if (n_total < 2)
        exp_status = STAT_RUNT;
      else if (residue != 8'h00)
        exp_status = STAT_CRC_ERR;
      else
        exp_status = STAT_OK;
      exp_len = (n_total > DEPTH) ? DEPTH : n_total;
      send_frame(row_extra[t]);
      wait_done(got_done);
      if (row_lock[t])
      begin
        if (!got_done)
        begin
          note_error();
          $display("ERROR %s: frame_done never came within %0d cycles", cur_test, DONE_TIMEOUT);
        end
        else
        begin
          check_status(exp_status, frame_status);
          check_len((ADDR_W+1)'(exp_len), frame_len);
          read_buffer(exp_len);
        end
        check_flag("rx_start pulse", 1'b1, start_count == 1);
      end
      else
      begin
        if (got_done)
        begin
          note_error();
          $display("ERROR %s: frame_done came although phaselock was low", cur_test);
        end
        check_flag("rx_start pulse", 1'b0, start_count != 0);
      end
      $display("test %s: %s", cur_test, (test_errors == 0) ? "ok" : "has errors");
      repeat (4) @(negedge clk);
    end
    $display("tests %0d checks %0d errors %0d", N_TESTS, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
rtl/rx_link_pkg.sv
rtl/rx_bit_framer.sv
rtl/rx_link_control.sv
rtl/crc8_engine.sv
rtl/frame_buffer.sv
rtl/frame_status.sv
rtl/rx_link_top.sv
bench/tb_rx_link.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rx_link
FILELIST  = src.f
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
